// File: design/color_classifier.sv
`timescale 1ns/1ps

module color_classifier #(
	parameter logic [color_seg_pkg::pix_w-1:0] hue_tol = color_seg_pkg::hue_tol_default
) (
	input  logic                             clk_llc,
	input  logic                             resetx,
	pix3_if.dst                              hsv,
	output logic                             out_valid,
	input  logic                             out_ready,
	output logic [color_seg_pkg::mask_w-1:0] out_mask
);
	import color_seg_pkg::*;

	logic              load;
	logic              is_black;
	logic              is_chroma;   // saturated enough to carry a hue
	logic              is_white;
	logic              is_red;
	logic              is_orange;
	logic              is_yellow;
	logic              is_green;
	logic              is_blue;
	logic [mask_w-1:0] mask_d;

	// open band around a centre, bounds wrap mod 256
	function automatic logic in_band(
		input logic [pix_w-1:0] h,
		input logic [pix_w-1:0] centre
	);
		logic [pix_w-1:0] lo;
		logic [pix_w-1:0] hi;
		lo = centre - hue_tol;
		hi = centre + hue_tol;
		return (lo < h) && (h < hi);
	endfunction

	assign load      = ~out_valid | out_ready;
	assign hsv.ready = load;

	// ch0 = h, ch1 = s, ch2 = v
	assign is_black  = hsv.ch2 < val_black;
	assign is_chroma = ~is_black & (hsv.ch1 > sat_chroma);
	assign is_white  = (hsv.ch1 < sat_white) & (hsv.ch2 > val_white);
	assign is_red    = is_chroma & in_band(hsv.ch0, hue_red);
	assign is_orange = is_chroma & in_band(hsv.ch0, hue_orange);
	assign is_yellow = is_chroma & in_band(hsv.ch0, hue_yellow);
	assign is_green  = is_chroma & in_band(hsv.ch0, hue_green);
	assign is_blue   = is_chroma & in_band(hsv.ch0, hue_blue);

	// ----------------------------------------------------------------------
	// mask word, msb first
	// ----------------------------------------------------------------------
	assign mask_d = {
		is_white | is_red | is_orange | is_yellow,                        // 15
		is_white | is_red | is_orange | is_yellow | is_black,             // 14
		is_white | is_red,                                                // 13
		is_red,
		is_orange,
		is_white | is_green | is_yellow,                                  // 10
		is_white | is_green | is_yellow | is_orange | is_black,           // 9
		is_white | is_green | is_yellow | is_orange,
		is_white,                                                         // 7
		is_green,
		is_yellow,
		is_white | is_blue,                                               // 4
		is_white | is_blue | is_black,
		is_white | is_blue,                                               // 2, same as 4
		is_blue,
		is_black                                                          // 0
	};

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (~resetx)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= hsv.valid;
	end

	always_ff @(posedge clk_llc)
	begin
		if (load)
			out_mask <= mask_d;
	end

endmodule

// File: design/color_seg_pkg.sv
package color_seg_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int pix_w  = 8;    // one channel of a pixel
	localparam int mask_w = 16;   // class word

	// ----------------------------------------------------------------------
	// ycbcr -> rgb, 8 fractional bits
	// ----------------------------------------------------------------------
	localparam logic [9:0] coef_y  = 10'd298;   // 1.164 luma gain
	localparam logic [9:0] coef_rv = 10'd409;   // 1.596 cr to red
	localparam logic [9:0] coef_gv = 10'd208;   // 0.813 cr to green
	localparam logic [9:0] coef_gu = 10'd100;   // 0.392 cb to green
	localparam logic [9:0] coef_bu = 10'd516;   // 2.017 cb to blue

	localparam logic [7:0] luma_ofs   = 8'd16;
	localparam logic [7:0] chroma_ofs = 8'd128;

	// ----------------------------------------------------------------------
	// hsv scale, six sextants of 40 steps
	// ----------------------------------------------------------------------
	localparam logic [7:0] hue_sextant = 8'd40;
	localparam logic [7:0] hue_full    = 8'd240;

	// classifier thresholds
	localparam logic [7:0] sat_chroma = 8'd96;    // above this counts as coloured
	localparam logic [7:0] sat_white  = 8'd64;
	localparam logic [7:0] val_black  = 8'd96;
	localparam logic [7:0] val_white  = 8'd192;

	// hue centres on the 240 circle
	localparam logic [7:0] hue_red    = 8'd230;
	localparam logic [7:0] hue_orange = 8'd15;
	localparam logic [7:0] hue_yellow = 8'd40;
	localparam logic [7:0] hue_green  = 8'd90;
	localparam logic [7:0] hue_blue   = 8'd144;

	localparam logic [7:0] hue_tol_default = 8'd10;   // half width of a band

endpackage

// File: design/color_seg_top.sv
`timescale 1ns/1ps

module color_seg_top #(
	parameter logic [color_seg_pkg::pix_w-1:0] hue_tol = color_seg_pkg::hue_tol_default
) (
	input  logic                             clk_llc,
	input  logic                             resetx,
	input  logic                             in_valid,
	input  logic [color_seg_pkg::pix_w-1:0]  in_byte,
	output logic                             in_ready,
	output logic                             out_valid,
	output logic [color_seg_pkg::mask_w-1:0] out_mask,
	input  logic                             out_ready
);

	// ----------------------------------------------------------------------
	// stage links
	// ----------------------------------------------------------------------
	pix3_if ycc_bus ();   // y, cb, cr
	pix3_if rgb_bus ();   // r, g, b
	pix3_if hsv_bus ();   // h, s, v

	ycc_pair_unpack unpack_i (
		.clk_llc  (clk_llc),
		.resetx   (resetx),
		.in_valid (in_valid),
		.in_byte  (in_byte),
		.in_ready (in_ready),
		.ycc      (ycc_bus.src)
	);

	ycc_to_rgb ycc2rgb_i (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.ycc     (ycc_bus.dst),
		.rgb     (rgb_bus.src)
	);

	rgb_to_hsv rgb2hsv_i (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.rgb     (rgb_bus.dst),
		.hsv     (hsv_bus.src)
	);

	color_classifier #(
		.hue_tol (hue_tol)
	) classify_i (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.hsv       (hsv_bus.dst),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_mask  (out_mask)
	);

endmodule

// File: design/pix3_if.sv
`timescale 1ns/1ps

// three channel pixel stream, one pixel per transfer
interface pix3_if;
	import color_seg_pkg::*;

	logic             valid;   // pixel on ch0..ch2
	logic             ready;   // sink takes it this edge
	logic [pix_w-1:0] ch0;
	logic [pix_w-1:0] ch1;
	logic [pix_w-1:0] ch2;

	// producer side
	modport src (
		output valid, ch0, ch1, ch2,
		input  ready
	);

	// consumer side
	modport dst (
		input  valid, ch0, ch1, ch2,
		output ready
	);

endinterface

// File: design/rgb_to_hsv.sv
`timescale 1ns/1ps

module rgb_to_hsv (
	input  logic clk_llc,
	input  logic resetx,
	pix3_if.dst  rgb,
	pix3_if.src  hsv
);
	import color_seg_pkg::*;

	// which channel is largest
	localparam logic [1:0] sel_red = 2'd0;
	localparam logic [1:0] sel_grn = 2'd1;
	localparam logic [1:0] sel_blu = 2'd2;

	logic               v1;
	logic               load1;
	logic               load2;
	logic [pix_w-1:0]   r;
	logic [pix_w-1:0]   g;
	logic [pix_w-1:0]   b;
	logic [pix_w-1:0]   max_d;
	logic [pix_w-1:0]   min_d;
	logic [1:0]         sel_d;
	logic signed [8:0]  diff_d;   // signed hue difference
	logic [pix_w-1:0]   max_q;
	logic [pix_w-1:0]   delta_q;
	logic [1:0]         sel_q;
	logic signed [8:0]  diff_q;
	logic signed [15:0] h_num;
	logic signed [15:0] h_den;
	logic signed [15:0] h_quo;
	logic signed [15:0] h_off;
	logic [15:0]        s_num;
	logic [15:0]        s_den;
	logic [15:0]        s_quo;

	assign r = rgb.ch0;
	assign g = rgb.ch1;
	assign b = rgb.ch2;

	assign load2     = ~hsv.valid | hsv.ready;
	assign load1     = ~v1 | load2;
	assign rgb.ready = load1;

	// ----------------------------------------------------------------------
	// stage 1, max, min and the difference for the hue
	// ----------------------------------------------------------------------
	always_comb
	begin
		if (r >= g && r >= b)   // red wins ties
		begin
			sel_d  = sel_red;
			max_d  = r;
			diff_d = $signed({1'b0, g}) - $signed({1'b0, b});
		end
		else if (g >= b)
		begin
			sel_d  = sel_grn;
			max_d  = g;
			diff_d = $signed({1'b0, b}) - $signed({1'b0, r});
		end
		else
		begin
			sel_d  = sel_blu;
			max_d  = b;
			diff_d = $signed({1'b0, r}) - $signed({1'b0, g});
		end
		min_d = (r <= g && r <= b) ? r : ((g <= b) ? g : b);
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (~resetx)
		begin
			v1        <= 1'b0;
			hsv.valid <= 1'b0;
		end
		else
		begin
			if (load1)
				v1 <= rgb.valid;
			if (load2)
				hsv.valid <= v1;
		end
	end

	always_ff @(posedge clk_llc)
	begin
		if (load1)
		begin
			max_q   <= max_d;
			delta_q <= max_d - min_d;
			sel_q   <= sel_d;
			diff_q  <= diff_d;
		end
	end

	// ----------------------------------------------------------------------
	// stage 2, hue and saturation
	// ----------------------------------------------------------------------
	// divisors forced to 1 for grey and black, result is 0 there anyway
	assign h_num = $signed({8'b0, hue_sextant}) * diff_q;
	assign h_den = (delta_q == '0) ? 16'sd1 : $signed({8'b0, delta_q});
	assign h_quo = h_num / h_den;   // truncates toward zero

	always_comb
	begin
		case (sel_q)
			sel_red:
			begin
				h_off = h_quo + $signed({8'b0, hue_full});
				if (h_off >= $signed({8'b0, hue_full}))   // wrap past 240
					h_off = h_off - $signed({8'b0, hue_full});
			end
			sel_grn: h_off = h_quo + $signed({7'b0, hue_sextant, 1'b0});   // +80
			default: h_off = h_quo + $signed({6'b0, hue_sextant, 2'b00});  // +160
		endcase
	end

	assign s_num = {8'b0, delta_q} * 16'd255;
	assign s_den = (max_q == '0) ? 16'd1 : {8'b0, max_q};
	assign s_quo = s_num / s_den;

	always_ff @(posedge clk_llc)
	begin
		if (load2)
		begin
			hsv.ch0 <= h_off[pix_w-1:0];   // grey lands on red, wraps to 0
			hsv.ch1 <= s_quo[pix_w-1:0];
			hsv.ch2 <= max_q;   // value
		end
	end

endmodule

// File: design/ycc_pair_unpack.sv
`timescale 1ns/1ps

module ycc_pair_unpack (
	input  logic                           clk_llc,
	input  logic                           resetx,
	input  logic                           in_valid,
	input  logic [color_seg_pkg::pix_w-1:0] in_byte,
	output logic                           in_ready,
	pix3_if.src                            ycc
);
	import color_seg_pkg::*;

	// byte order inside one 4:2:2 group
	localparam logic [1:0] byte_cb = 2'd0;
	localparam logic [1:0] byte_y0 = 2'd1;
	localparam logic [1:0] byte_cr = 2'd2;
	localparam logic [1:0] byte_y1 = 2'd3;

	logic [1:0]       cnt;     // position in group
	logic             take;    // byte accepted this edge
	logic [pix_w-1:0] cb_q;    // shared by both pixels
	logic [pix_w-1:0] y0_q;    // waits for cr
	logic [pix_w-1:0] cr_q;    // kept for pixel 1

	// free when nothing is waiting on the output
	assign in_ready = ~ycc.valid | ycc.ready;
	assign take     = in_valid & in_ready;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (~resetx)
		begin
			cnt       <= 2'd0;
			ycc.valid <= 1'b0;
		end
		else
		begin
			if (take)
				cnt <= cnt + 2'd1;   // wraps back to cb
			// cr and y1 each finish a pixel
			if (in_ready)
				ycc.valid <= take & cnt[1];
		end
	end

	// ----------------------------------------------------------------------
	// byte capture and pixel assembly
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (take)
		begin
			case (cnt)
				byte_cb: cb_q <= in_byte;
				byte_y0: y0_q <= in_byte;
				byte_cr:
				begin
					cr_q    <= in_byte;
					ycc.ch0 <= y0_q;      // pixel 0
					ycc.ch1 <= cb_q;
					ycc.ch2 <= in_byte;
				end
				byte_y1:
				begin
					ycc.ch0 <= in_byte;   // pixel 1, same chroma
					ycc.ch1 <= cb_q;
					ycc.ch2 <= cr_q;
				end
			endcase
		end
	end

endmodule

// File: design/ycc_to_rgb.sv
`timescale 1ns/1ps

module ycc_to_rgb (
	input  logic clk_llc,
	input  logic resetx,
	pix3_if.dst  ycc,
	pix3_if.src  rgb
);
	import color_seg_pkg::*;

	logic               v1;      // stage 1 holds products
	logic               load1;
	logic               load2;
	logic signed [9:0]  y_d;     // offset removed
	logic signed [9:0]  cb_d;
	logic signed [9:0]  cr_d;
	logic signed [19:0] p_y;     // luma term
	logic signed [19:0] p_rv;
	logic signed [19:0] p_gv;
	logic signed [19:0] p_gu;
	logic signed [19:0] p_bu;
	logic signed [19:0] r_sum;
	logic signed [19:0] g_sum;
	logic signed [19:0] b_sum;

	// drop 8 fraction bits and saturate to a byte
	function automatic logic [pix_w-1:0] clamp8(input logic signed [19:0] s);
		logic signed [19:0] sh;
		sh = s >>> 8;
		if (sh < 0)
			return '0;
		else if (sh > 20'sd255)
			return '1;
		else
			return sh[pix_w-1:0];
	endfunction

	// stall ripples back one stage per cycle
	assign load2     = ~rgb.valid | rgb.ready;
	assign load1     = ~v1 | load2;
	assign ycc.ready = load1;

	assign y_d  = $signed({2'b00, ycc.ch0}) - $signed({2'b00, luma_ofs});
	assign cb_d = $signed({2'b00, ycc.ch1}) - $signed({2'b00, chroma_ofs});
	assign cr_d = $signed({2'b00, ycc.ch2}) - $signed({2'b00, chroma_ofs});

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (~resetx)
		begin
			v1        <= 1'b0;
			rgb.valid <= 1'b0;
		end
		else
		begin
			if (load1)
				v1 <= ycc.valid;
			if (load2)
				rgb.valid <= v1;
		end
	end

	// ----------------------------------------------------------------------
	// stage 1, products
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (load1)
		begin
			p_y  <= $signed({1'b0, coef_y}) * y_d;
			p_rv <= $signed({1'b0, coef_rv}) * cr_d;
			p_gv <= $signed({1'b0, coef_gv}) * cr_d;
			p_gu <= $signed({1'b0, coef_gu}) * cb_d;
			p_bu <= $signed({1'b0, coef_bu}) * cb_d;
		end
	end

	// stage 2, sums then clamp
	assign r_sum = p_y + p_rv;
	assign g_sum = p_y - p_gv - p_gu;
	assign b_sum = p_y + p_bu;

	always_ff @(posedge clk_llc)
	begin
		if (load2)
		begin
			rgb.ch0 <= clamp8(r_sum);
			rgb.ch1 <= clamp8(g_sum);
			rgb.ch2 <= clamp8(b_sum);
		end
	end

endmodule

// File: test/color_seg_stimulus.txt
# name  cb y0 cr y1 (hex bytes, stream order)  mask_y0 mask_y1 (hex)
# each line is one 4:2:2 group, both pixels share cb and cr
black_pair    80 10 80 28  4209 4209
white_sat     80 EB 80 FF  E79C E79C
grey_mid      80 7E 80 64  0000 0000
green_pair    52 97 1E 78  0740 0740
blue_pair     D3 5B 49 3C  001E 001E
red_pair      76 58 EB 64  F000 F000
orange_pair   3E 82 CD 6E  CB00 CB00
yellow_pair   10 D2 92 B4  C720 C720
clamp_cyan    F0 80 10 C8  0000 0000
clamp_orange  10 80 F0 3C  CB00 0000
tint_white    84 E6 7C C8  E79C E79C
dark_red      80 1E AA 10  4209 4209
mix_green     52 97 1E 20  0740 0000
white_black   80 EB 80 10  E79C 4209
grey_dark     80 5A 80 5B  4209 4209
grey_light    80 BE 80 C8  E79C E79C
grey_edge     80 B4 80 B8  0000 E79C
red_again     76 58 EB 64  F000 F000
blue_again    D3 5B 49 3C  001E 001E
orange_again  3E 82 CD 6E  CB00 CB00
yellow_again  10 D2 92 B4  C720 C720
green_again   52 97 1E 78  0740 0740

// File: test/tb_color_seg.sv
`timescale 1ns/1ps

module tb_color_seg;
	import color_seg_pkg::*;

	localparam int cycle_ns = 8;

	logic              clk_llc;
	logic              resetx;
	logic              in_valid;
	logic [pix_w-1:0]  in_byte;
	logic              in_ready;
	logic              out_valid;
	logic [mask_w-1:0] out_mask;
	logic              out_ready;

	string             test_name [$];   // one per 4:2:2 group
	logic [pix_w-1:0]  byte_q [$];      // cb y0 cr y1 per group
	logic [mask_w-1:0] exp_q [$];       // two words per group, y0 first
	bit                loaded;
	bit                words_done;
	int                n_pass;
	int                n_fail;
	int                n_errors;        // not tied to one test

	color_seg_top #(
		.hue_tol (hue_tol_default)
	) dut_i (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.in_valid  (in_valid),
		.in_byte   (in_byte),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_mask  (out_mask),
		.out_ready (out_ready)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever
			#(cycle_ns / 2) clk_llc = ~clk_llc;
	end

	// ----------------------------------------------------------------------
	// stimulus file, name then six hex fields
	// ----------------------------------------------------------------------
	task automatic read_stimulus();
		int                fd;
		int                n;
		string             line;
		string             name;
		logic [pix_w-1:0]  cb;
		logic [pix_w-1:0]  y0;
		logic [pix_w-1:0]  cr;
		logic [pix_w-1:0]  y1;
		logic [mask_w-1:0] m0;
		logic [mask_w-1:0] m1;
		fd = $fopen("test/color_seg_stimulus.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line[0] != "#")   // skip column notes
			begin
				n = $sscanf(line, "%s %h %h %h %h %h %h",
					name, cb, y0, cr, y1, m0, m1);
				if (n == 7)
				begin
					test_name.push_back(name);
					byte_q.push_back(cb);
					byte_q.push_back(y0);
					byte_q.push_back(cr);
					byte_q.push_back(y1);
					exp_q.push_back(m0);
					exp_q.push_back(m1);
				end
			end
		end
		$fclose(fd);
	endtask

	// bytes go out on the falling edge, 0..3 idle cycles before each
	task automatic drive_bytes();
		int idle;
		for (int i = 0; i < byte_q.size(); i++)
		begin
			idle = $urandom_range(0, 3);
			repeat (idle)
			begin
				@(negedge clk_llc);
				in_valid = 1'b0;
			end
			@(negedge clk_llc);
			in_valid = 1'b1;
			in_byte  = byte_q[i];
			@(posedge clk_llc);
			while (!in_ready)   // held until taken
				@(posedge clk_llc);
		end
		@(negedge clk_llc);
		in_valid = 1'b0;
	endtask

	task automatic toggle_ready();
		while (!words_done)
		begin
			@(negedge clk_llc);
			out_ready = ($urandom_range(0, 3) != 0);   // high about 3 in 4
		end
	endtask

	// ----------------------------------------------------------------------
	// output words in order, one report line per group
	// ----------------------------------------------------------------------
	task automatic check_words();
		int                k;
		logic [mask_w-1:0] got [2];
		for (int g = 0; g < test_name.size(); g++)
		begin
			k = 0;
			while (k < 2)
			begin
				@(posedge clk_llc);
				if (out_valid && out_ready)   // handshake edge
				begin
					got[k] = out_mask;
					k++;
				end
			end
			if (got[0] !== exp_q[2*g] || got[1] !== exp_q[2*g+1])
			begin
				$display("[FAIL] %s expected %h %h actual %h %h", test_name[g],
					exp_q[2*g], exp_q[2*g+1], got[0], got[1]);
				n_fail++;
			end
			else
			begin
				$display("[PASS] %s %h %h", test_name[g], got[0], got[1]);
				n_pass++;
			end
		end
		words_done = 1'b1;
	endtask

	// nothing may follow the last expected word
	task automatic watch_for_extra(input int cycles);
		int extra;
		extra = 0;
		repeat (cycles)
		begin
			@(posedge clk_llc);
			if (out_valid && out_ready)
				extra++;
		end
		if (extra != 0)
		begin
			$display("error: %0d output words came after the last expected one", extra);
			n_errors++;
		end
	endtask

	// worst case 8 cycles a byte, plus room to drain
	initial
	begin
		wait (loaded);
		#(test_name.size() * 4 * 8 * cycle_ns + 100 * cycle_ns);
		$display("timeout: not all output words arrived in time");
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(15718));
		resetx     = 1'b0;
		in_valid   = 1'b0;
		in_byte    = '0;
		out_ready  = 1'b0;
		n_pass     = 0;
		n_fail     = 0;
		n_errors   = 0;
		words_done = 1'b0;
		read_stimulus();
		loaded = 1'b1;
		repeat (2) @(posedge clk_llc);
		@(negedge clk_llc);
		resetx = 1'b1;
		if (test_name.size() == 0)
		begin
			$display("error: no test groups read from test/color_seg_stimulus.txt");
			n_errors++;
		end
		else
		begin
			fork
				drive_bytes();
				toggle_ready();
				check_words();
			join
			@(negedge clk_llc);
			out_ready = 1'b1;
			watch_for_extra(20);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d other errors",
			test_name.size(), n_pass, n_fail, n_errors);
		if (n_fail == 0 && n_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: vlog.f
design/color_seg_pkg.sv
design/pix3_if.sv
design/ycc_pair_unpack.sv
design/ycc_to_rgb.sv
design/rgb_to_hsv.sv
design/color_classifier.sv
design/color_seg_top.sv
test/tb_color_seg.sv
